// ==== all.f ====
src/mem_pkg.sv
src/mem_req_if.sv
src/mem_stage.sv
src/lsu_ctrl.sv
src/wait_timer.sv
src/dmem_ram.sv
src/load_align.sv
src/mem_subsys.sv
verification/mem_subsys_asserts.sv
verification/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory-stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_subsys \
	--Mdir obj_dir -o tb_mem_subsys \
	-f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_mem_subsys > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
	exit 1
fi
if ! grep -q "RESULT: PASS" "$log"; then
	echo "no result line in $log"
	exit 1
fi
exit 0

// ==== src/dmem_ram.sv ====
/*
 * dmem_ram
 * Local data RAM, one word per entry. Sized stores use byte
 * lanes, reads return the whole word. Zeroed by a sweep that
 * runs over ram_words cycles once reset is released.
 */
`timescale 1ns/1ps
`default_nettype none

module dmem_ram #(
	parameter int ram_words = 256
) (
	input  logic  clk,
	input  logic  rst_n,
	mem_req_if.ram mem
);

	localparam int idx_w = $clog2(ram_words);

	mem_pkg::word_t ram [ram_words];
	logic [idx_w-1:0] idx;
	logic [idx_w-1:0] sweep_idx;
	logic             sweep_on;
	logic [3:0]       be;
	mem_pkg::word_t   lane_data;

	assign idx       = mem.addr[idx_w+1:2];
	assign mem.rdata = ram[idx];

	// byte enables and replicated lane data
	always_comb begin
		case (mem.size[1:0])
			2'b00: begin
				be        = 4'b0001 << mem.addr[1:0];
				lane_data = {4{mem.wdata[7:0]}};
			end
			2'b01: begin
				be        = mem.addr[1] ? 4'b1100 : 4'b0011;
				lane_data = {2{mem.wdata[15:0]}};
			end
			default: begin
				be        = 4'b1111;
				lane_data = mem.wdata;
			end
		endcase
	end

	// ----------------------------------------
	// clear sweep
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sweep_idx <= '0;
			sweep_on  <= 1'b1;
		end else if (sweep_on) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (sweep_idx == idx_w'(ram_words - 1)) begin
				sweep_on <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sweep_on) begin
			ram[sweep_idx] <= '0;
		end else if (mem.req && mem.op == mem_pkg::op_store) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i]) begin
					ram[idx][8*i +: 8] <= lane_data[8*i +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/load_align.sv ====
/*
 * load_align
 * Picks the loaded lane, sign or zero extends it by size and
 * holds the write-back result. ALU results pass straight through.
 */
`timescale 1ns/1ps
`default_nettype none

module load_align (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 done,
	input  mem_pkg::reg_idx_t    rd,
	input  logic                 we,
	mem_req_if.align             mem,
	output logic                 wb_valid,
	output mem_pkg::reg_idx_t    wb_rd,
	output logic                 wb_we,
	output mem_pkg::word_t       wb_data,
	output logic                 wb_nc
);

	mem_pkg::word_t ld_word;
	mem_pkg::word_t ld_ext;
	mem_pkg::word_t result;
	logic [7:0]     lane_b;
	logic [15:0]    lane_h;

	assign lane_b = ld_word[8*mem.addr[1:0] +: 8];
	assign lane_h = mem.addr[1] ? ld_word[31:16] : ld_word[15:0];

	always_comb begin
		case (mem.size)
			mem_pkg::sz_b:  ld_ext = {{24{lane_b[7]}}, lane_b};
			mem_pkg::sz_bu: ld_ext = {24'b0, lane_b};
			mem_pkg::sz_h:  ld_ext = {{16{lane_h[15]}}, lane_h};
			mem_pkg::sz_hu: ld_ext = {16'b0, lane_h};
			default:        ld_ext = ld_word;
		endcase
	end

	// stores write back nothing
	always_comb begin
		case (mem.op)
			mem_pkg::op_alu:  result = mem.addr;
			mem_pkg::op_load: result = ld_ext;
			default:          result = '0;
		endcase
	end

	// ----------------------------------------
	// ram word sampled at ack
	always_ff @(posedge clk) begin
		if (mem.ack) begin
			ld_word <= mem.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= done;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			wb_rd   <= rd;
			wb_we   <= we && (mem.op != mem_pkg::op_store);
			wb_data <= result;
			wb_nc   <= mem.nc;
		end
	end

endmodule

`default_nettype wire

// ==== src/lsu_ctrl.sv ====
/*
 * lsu_ctrl
 * Sequences the held access: request, wait for the region
 * latency, then write-back. Also produces the busy signal
 * that keeps execute from offering a second instruction.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl #(
	parameter int cache_lat = 1,
	parameter int nc_lat    = 6,
	parameter int cnt_w     = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             held,
	output logic             done,
	output logic             busy,
	output logic             load_lat,
	output logic [cnt_w-1:0] lat,
	input  logic             expired,
	mem_req_if.ctrl          mem
);

	mem_pkg::lsu_state_t state;
	mem_pkg::lsu_state_t state_nxt;

	// memory op waiting in idle starts the timer
	assign load_lat = (state == mem_pkg::st_idle) && held && (mem.op != mem_pkg::op_alu);
	assign lat      = mem.nc ? cnt_w'(nc_lat) : cnt_w'(cache_lat);

	assign done = (state == mem_pkg::st_done);
	assign busy = held || (state != mem_pkg::st_idle);
	assign mem.ack = (state == mem_pkg::st_wait) && expired;

	// ----------------------------------------
	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			mem_pkg::st_idle: begin
				if (held) begin
					if (mem.op == mem_pkg::op_alu) begin
						state_nxt = mem_pkg::st_done;
					end else begin
						state_nxt = mem_pkg::st_wait;
					end
				end
			end
			mem_pkg::st_wait: begin
				if (expired) begin
					state_nxt = mem_pkg::st_done;
				end
			end
			default: begin
				state_nxt = mem_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= mem_pkg::st_idle;
			mem.req <= 1'b0;
		end else begin
			state   <= state_nxt;
			// one cycle wide, first cycle of st_wait
			mem.req <= load_lat;
		end
	end

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
/*
 * mem_pkg
 * Shared definitions for the memory-access stage: data and
 * address widths, operation and access size codes, and the
 * state encoding of the load/store controller.
 */
`default_nettype none

package mem_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;

	// operation held in the stage
	typedef enum logic [1:0] {
		op_alu   = 2'd0,
		op_load  = 2'd1,
		op_store = 2'd2
	} mem_op_t;

	// funct3 layout, top bit marks unsigned
	typedef logic [2:0] mem_size_t;

	localparam mem_size_t sz_b  = 3'b000;
	localparam mem_size_t sz_h  = 3'b001;
	localparam mem_size_t sz_w  = 3'b010;
	localparam mem_size_t sz_bu = 3'b100;
	localparam mem_size_t sz_hu = 3'b101;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_done
	} lsu_state_t;

endpackage

`default_nettype wire

// ==== src/mem_req_if.sv ====
/*
 * mem_req_if
 * One memory request and its response, shared by the stage
 * register, the controller, the data RAM and the load aligner.
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

	// request
	logic                req;
	mem_pkg::mem_op_t    op;
	mem_pkg::mem_size_t  size;
	mem_pkg::addr_t      addr;
	mem_pkg::word_t      wdata;
	logic                nc;

	// response
	mem_pkg::word_t      rdata;
	logic                ack;

	modport stage (output op, size, addr, wdata, nc);
	modport ctrl  (input op, nc, output req, ack);
	modport ram   (input req, op, size, addr, wdata, output rdata);
	modport align (input op, size, addr, nc, rdata, ack);

endinterface

`default_nettype wire

// ==== src/mem_stage.sv ====
/*
 * mem_stage
 * Execute-to-memory register. Captures one unkilled instruction,
 * picks the store data from the write-back bypass when asked and
 * tags the access as cacheable or not from the CSR mask and base.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ex_valid,
	input  logic                 ex_kill,
	input  mem_pkg::mem_op_t     ex_op,
	input  mem_pkg::mem_size_t   ex_size,
	input  mem_pkg::addr_t       ex_addr,
	input  mem_pkg::word_t       ex_wdata,
	input  logic                 ex_bp_sel,
	input  mem_pkg::word_t       wb_bp_data,
	input  mem_pkg::reg_idx_t    ex_rd,
	input  logic                 ex_we,
	input  mem_pkg::addr_t       csr_nc_mask,
	input  mem_pkg::addr_t       csr_nc_base,
	output logic                 held,
	output mem_pkg::reg_idx_t    rd,
	output logic                 we,
	input  logic                 done,
	mem_req_if.stage             mem
);

	logic           accept;
	logic           nc_hit;
	mem_pkg::word_t st_data;

	assign accept  = ex_valid && !ex_kill;
	assign nc_hit  = (ex_addr & csr_nc_mask) == csr_nc_base;
	// bypass wins over the register file value
	assign st_data = ex_bp_sel ? wb_bp_data : ex_wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held <= 1'b0;
		end else if (done) begin
			held <= 1'b0;
		end else if (accept) begin
			held <= 1'b1;
		end
	end

	// ----------------------------------------
	// payload, loaded on accept only
	always_ff @(posedge clk) begin
		if (accept) begin
			mem.op    <= ex_op;
			mem.size  <= ex_size;
			mem.addr  <= ex_addr;
			mem.wdata <= st_data;
			mem.nc    <= nc_hit;
			rd        <= ex_rd;
			we        <= ex_we;
		end
	end

endmodule

`default_nettype wire

// ==== src/mem_subsys.sv ====
/*
 * mem_subsys
 * Memory-access stage top level: stage register, controller,
 * latency timer, data RAM and load aligner on plain ports.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
	parameter int ram_words = 256,
	parameter int cache_lat = 1,
	parameter int nc_lat    = 6,
	parameter int cnt_w     = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ex_valid,
	input  logic                 ex_kill,
	input  mem_pkg::mem_op_t     ex_op,
	input  mem_pkg::mem_size_t   ex_size,
	input  mem_pkg::addr_t       ex_addr,
	input  mem_pkg::word_t       ex_wdata,
	input  logic                 ex_bp_sel,
	input  mem_pkg::word_t       wb_bp_data,
	input  mem_pkg::reg_idx_t    ex_rd,
	input  logic                 ex_we,
	input  mem_pkg::addr_t       csr_nc_mask,
	input  mem_pkg::addr_t       csr_nc_base,
	output logic                 busy,
	output logic                 wb_valid,
	output mem_pkg::reg_idx_t    wb_rd,
	output logic                 wb_we,
	output mem_pkg::word_t       wb_data,
	output logic                 wb_nc
);

	logic              held;
	logic              done;
	logic              load_lat;
	logic [cnt_w-1:0]  lat;
	logic              expired;
	mem_pkg::reg_idx_t rd;
	logic              we;

	mem_req_if u_mem ();

	mem_stage u_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_valid    (ex_valid),
		.ex_kill     (ex_kill),
		.ex_op       (ex_op),
		.ex_size     (ex_size),
		.ex_addr     (ex_addr),
		.ex_wdata    (ex_wdata),
		.ex_bp_sel   (ex_bp_sel),
		.wb_bp_data  (wb_bp_data),
		.ex_rd       (ex_rd),
		.ex_we       (ex_we),
		.csr_nc_mask (csr_nc_mask),
		.csr_nc_base (csr_nc_base),
		.held        (held),
		.rd          (rd),
		.we          (we),
		.done        (done),
		.mem         (u_mem.stage)
	);

	lsu_ctrl #(
		.cache_lat (cache_lat),
		.nc_lat    (nc_lat),
		.cnt_w     (cnt_w)
	) u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.held     (held),
		.done     (done),
		.busy     (busy),
		.load_lat (load_lat),
		.lat      (lat),
		.expired  (expired),
		.mem      (u_mem.ctrl)
	);

	wait_timer #(
		.cnt_w (cnt_w)
	) u_timer (
		.clk      (clk),
		.rst_n    (rst_n),
		.load_lat (load_lat),
		.lat      (lat),
		.expired  (expired)
	);

	dmem_ram #(
		.ram_words (ram_words)
	) u_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.mem   (u_mem.ram)
	);

	load_align u_align (
		.clk      (clk),
		.rst_n    (rst_n),
		.done     (done),
		.rd       (rd),
		.we       (we),
		.mem      (u_mem.align),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_we    (wb_we),
		.wb_data  (wb_data),
		.wb_nc    (wb_nc)
	);

endmodule

`default_nettype wire

// ==== src/wait_timer.sv ====
/*
 * wait_timer
 * Down counter for the access latency. Loaded with the region
 * latency, it flags expiry for one cycle when it hits zero.
 */
`timescale 1ns/1ps
`default_nettype none

module wait_timer #(
	parameter int cnt_w = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load_lat,
	input  logic [cnt_w-1:0] lat,
	output logic             expired
);

	logic [cnt_w-1:0] cnt;
	logic             armed;

	assign expired = armed && (cnt == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt   <= '0;
			armed <= 1'b0;
		end else if (load_lat) begin
			cnt   <= lat;
			armed <= 1'b1;
		end else if (armed) begin
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				// expiry seen, back to idle
				armed <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/mem_subsys_asserts.sv ====
/*
 * mem_subsys_asserts
 * Protocol checks on the load/store controller: one-cycle
 * request and acknowledge, no offer while busy, acknowledge
 * only while waiting on memory and after the request cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_asserts (
	input logic                clk,
	input logic                rst_n,
	input mem_pkg::lsu_state_t state,
	input logic                req,
	input logic                ack,
	input logic                busy,
	input logic                ex_valid
);

	// strobes last one cycle
	req_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) req |=> !req)
		else $error("req high for more than one cycle");

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else $error("ack high for more than one cycle");

	// execute holds off while the stage is occupied
	no_offer_busy: assert property (@(posedge clk) disable iff (!rst_n) ex_valid |-> !busy)
		else $error("ex_valid offered while busy");

	// ack only in st_wait and never in the req cycle
	ack_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> (state == mem_pkg::st_wait) && !req)
		else $error("ack outside the wait state or in the req cycle");

endmodule

`default_nettype wire

// ==== verification/tb_mem_subsys.sv ====
/*
 * tb_mem_subsys
 * Testbench for the memory-access stage. Offers random ALU,
 * load and store instructions, some of them killed, and checks
 * each write-back against a byte-level model of the data RAM.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

	localparam int ram_words  = 256;
	localparam int cache_lat  = 1;
	localparam int nc_lat     = 6;
	localparam int cnt_w      = 4;
	localparam int n_instr    = 300;
	localparam int rst_cycles = 10;
	localparam int max_cycles = 2 * (n_instr * (nc_lat + 3) + rst_cycles + ram_words);
	// bit 16 marks the uncached region
	localparam mem_pkg::addr_t nc_mask = 32'h0001_0000;
	localparam mem_pkg::addr_t nc_base = 32'h0001_0000;

	logic clk = 1'b0;
	logic rst_n;
	logic ex_valid, ex_kill, ex_bp_sel, ex_we;
	mem_pkg::mem_op_t   ex_op;
	mem_pkg::mem_size_t ex_size;
	mem_pkg::addr_t     ex_addr, csr_nc_mask, csr_nc_base;
	mem_pkg::word_t     ex_wdata, wb_bp_data, wb_data;
	mem_pkg::reg_idx_t  ex_rd, wb_rd;
	logic busy, wb_valid, wb_we, wb_nc;

	logic [7:0] model_mem [ram_words * 4];
	mem_pkg::mem_size_t sizes [5] = '{mem_pkg::sz_b, mem_pkg::sz_h, mem_pkg::sz_w,
		mem_pkg::sz_bu, mem_pkg::sz_hu};
	integer seed = 14133;
	int errors   = 0;
	int n_fail   = 0;
	int accepted = 0;
	int wb_seen  = 0;
	int cyc      = 0;

	mem_subsys #(
		.ram_words (ram_words),
		.cache_lat (cache_lat),
		.nc_lat    (nc_lat),
		.cnt_w     (cnt_w)
	) u_dut (
		.clk (clk), .rst_n (rst_n),
		.ex_valid (ex_valid), .ex_kill (ex_kill), .ex_op (ex_op), .ex_size (ex_size),
		.ex_addr (ex_addr), .ex_wdata (ex_wdata), .ex_bp_sel (ex_bp_sel),
		.wb_bp_data (wb_bp_data), .ex_rd (ex_rd), .ex_we (ex_we),
		.csr_nc_mask (csr_nc_mask), .csr_nc_base (csr_nc_base),
		.busy (busy), .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_we (wb_we),
		.wb_data (wb_data), .wb_nc (wb_nc)
	);

	// controller protocol checks
	bind lsu_ctrl mem_subsys_asserts u_asserts (
		.clk      (clk),
		.rst_n    (rst_n),
		.state    (state),
		.req      (mem.req),
		.ack      (mem.ack),
		.busy     (busy),
		.ex_valid (tb_mem_subsys.ex_valid)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("timeout: run exceeded %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// counts every write-back pulse
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			wb_seen <= wb_seen + 1;
		end
	end

	// ----------------------------------------
	// compare tasks
	task automatic check_word(input string name, input mem_pkg::word_t exp,
			input mem_pkg::word_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_rd(input string name, input mem_pkg::reg_idx_t exp,
			input mem_pkg::reg_idx_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	// ----------------------------------------
	// RAM model, little endian bytes
	function automatic mem_pkg::word_t model_load(input mem_pkg::addr_t a,
			input mem_pkg::mem_size_t sz);
		int unsigned b;
		mem_pkg::word_t w;
		b = a % (ram_words * 4);
		case (sz)
			mem_pkg::sz_b:  w = {{24{model_mem[b][7]}}, model_mem[b]};
			mem_pkg::sz_bu: w = {24'b0, model_mem[b]};
			mem_pkg::sz_h:  w = {{16{model_mem[b + 1][7]}}, model_mem[b + 1], model_mem[b]};
			mem_pkg::sz_hu: w = {16'b0, model_mem[b + 1], model_mem[b]};
			default: w = {model_mem[b + 3], model_mem[b + 2], model_mem[b + 1], model_mem[b]};
		endcase
		return w;
	endfunction

	function automatic void model_store(input mem_pkg::addr_t a, input mem_pkg::mem_size_t sz,
			input mem_pkg::word_t d);
		int unsigned b;
		b = a % (ram_words * 4);
		for (int i = 0; i < (1 << sz[1:0]); i++) begin
			model_mem[b + i] = d[8*i +: 8];
		end
	endfunction

	// offers one instruction and checks its write-back
	task automatic run_one(input int idx, input mem_pkg::mem_op_t op,
			input mem_pkg::mem_size_t sz, input mem_pkg::addr_t addr, input logic kill);
		mem_pkg::word_t wdata, bp_data, exp_data;
		mem_pkg::reg_idx_t rd;
		logic we, bp_sel, exp_nc;
		int lat, exp_lat, err0;
		string name;
		err0    = errors;
		wdata   = $random(seed);
		bp_data = $random(seed);
		bp_sel  = 1'($random(seed));
		rd      = 5'($random(seed));
		we      = 1'($random(seed));
		exp_nc  = (addr & nc_mask) == nc_base;
		name    = $sformatf("test %0d %s%s", idx, op.name(), kill ? " killed" : "");
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
		@(posedge clk);
		ex_valid   <= 1'b1;
		ex_kill    <= kill;
		ex_op      <= op;
		ex_size    <= sz;
		ex_addr    <= addr;
		ex_wdata   <= wdata;
		ex_bp_sel  <= bp_sel;
		wb_bp_data <= bp_data;
		ex_rd      <= rd;
		ex_we      <= we;
		@(posedge clk);
		ex_valid <= 1'b0;
		ex_kill  <= 1'b0;
		if (kill) begin
			repeat (nc_lat + 3) begin
				@(negedge clk);
				if (wb_valid || busy) begin
					$display("%s: killed offer raised wb_valid or busy", name);
					errors++;
				end
			end
		end else begin
			accepted++;
			if (op == mem_pkg::op_store) begin
				model_store(addr, sz, bp_sel ? bp_data : wdata);
				exp_data = '0;
			end else if (op == mem_pkg::op_load) begin
				exp_data = model_load(addr, sz);
			end else begin
				exp_data = addr;
			end
			exp_lat = (op == mem_pkg::op_alu) ? 2 : (exp_nc ? nc_lat : cache_lat) + 3;
			lat = 0;
			@(negedge clk);
			while (!wb_valid && lat <= nc_lat + 3) begin
				if (!busy) begin
					$display("%s: busy low before wb_valid", name);
					errors++;
				end
				@(negedge clk);
				lat++;
			end
			if (!wb_valid) begin
				$display("%s: no wb_valid within %0d cycles", name, nc_lat + 4);
				errors++;
			end else begin
				check_cycles({name, " latency"}, exp_lat, lat);
				check_word({name, " wb_data"}, exp_data, wb_data);
				check_rd({name, " wb_rd"}, rd, wb_rd);
				check_flag({name, " wb_we"}, (op == mem_pkg::op_store) ? 1'b0 : we, wb_we);
				check_flag({name, " wb_nc"}, exp_nc, wb_nc);
				@(negedge clk);
				if (wb_valid) begin
					$display("%s: wb_valid longer than one cycle", name);
					errors++;
				end
			end
		end
		if (errors == err0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: failed", name);
			n_fail++;
		end
	endtask

	// ----------------------------------------
	// main sequence
	initial begin
		mem_pkg::mem_op_t   op;
		mem_pkg::mem_size_t sz;
		mem_pkg::addr_t     addr;
		mem_pkg::addr_t     last_addr;
		logic kill;
		logic recheck;
		for (int i = 0; i < ram_words * 4; i++) begin
			model_mem[i] = 8'h00;
		end
		rst_n       = 1'b0;
		ex_valid    = 1'b0;
		ex_kill     = 1'b0;
		ex_op       = mem_pkg::op_alu;
		ex_size     = mem_pkg::sz_w;
		ex_addr     = '0;
		ex_wdata    = '0;
		ex_bp_sel   = 1'b0;
		wb_bp_data  = '0;
		ex_rd       = '0;
		ex_we       = 1'b0;
		csr_nc_mask = nc_mask;
		csr_nc_base = nc_base;
		last_addr   = '0;
		recheck     = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		rst_n <= 1'b1;
		// RAM clear sweep
		repeat (ram_words + 2) @(posedge clk);
		for (int i = 0; i < n_instr; i++) begin
			if (recheck) begin
				// word load over a killed store
				op      = mem_pkg::op_load;
				sz      = mem_pkg::sz_w;
				addr    = last_addr & ~32'h3;
				kill    = 1'b0;
				recheck = 1'b0;
			end else begin
				op = mem_pkg::mem_op_t'($unsigned($random(seed)) % 3);
				if (op == mem_pkg::op_load) begin
					sz = sizes[$unsigned($random(seed)) % 5];
				end else begin
					sz = sizes[$unsigned($random(seed)) % 3];
				end
				// small window so loads hit earlier stores
				addr = $unsigned($random(seed)) % 64;
				addr = addr & ~((32'd1 << sz[1:0]) - 32'd1);
				if ($random(seed) & 1) begin
					addr = addr | nc_mask;
				end
				if (op == mem_pkg::op_alu) begin
					addr = $random(seed);
				end
				kill      = ($unsigned($random(seed)) % 8) == 0;
				recheck   = kill && (op == mem_pkg::op_store);
				last_addr = addr;
			end
			run_one(i, op, sz, addr, kill);
		end
		repeat (4) @(posedge clk);
		if (wb_seen != accepted) begin
			$display("%0d write-backs seen for %0d accepted instructions", wb_seen, accepted);
			errors++;
		end
		$display("tests %0d, failed %0d, check errors %0d", n_instr, n_fail, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
